/* include/bpf_consts.svh */
`ifndef BPF_CONSTS_SVH
`define BPF_CONSTS_SVH

// Address and length widths
`define BPF_CODE_AW       10
`define BPF_BYTE_AW       12
`define BPF_PLEN_W        16
`define BPF_SCRATCH_DEPTH 16

// Instruction class, opcode[2:0]
`define BPF_LD   3'h0
`define BPF_LDX  3'h1
`define BPF_ST   3'h2
`define BPF_STX  3'h3
`define BPF_ALU  3'h4
`define BPF_JMP  3'h5
`define BPF_RET  3'h6
`define BPF_MISC 3'h7

// Load size, opcode[4:3]
`define BPF_W 2'h0
`define BPF_H 2'h1
`define BPF_B 2'h2

// Masks applied to opcode[7:0]
`define BPF_MODE_MASK   8'he0
`define BPF_SRC_MASK    8'h08
`define BPF_OP_MASK     8'hf0
`define BPF_RVAL_MASK   8'h18
`define BPF_MISCOP_MASK 8'hf8

// Addressing modes
`define BPF_IMM 8'h00
`define BPF_ABS 8'h20
`define BPF_IND 8'h40
`define BPF_MEM 8'h60
`define BPF_LEN 8'h80
`define BPF_MSH 8'ha0

// Operand source
`define BPF_K 8'h00
`define BPF_X 8'h08

// Jump tests
`define BPF_JA   8'h00
`define BPF_JEQ  8'h10
`define BPF_JGT  8'h20
`define BPF_JGE  8'h30
`define BPF_JSET 8'h40

// Return value source and MISC ops
`define BPF_RET_K 8'h00
`define BPF_RET_A 8'h10
`define BPF_TAX   8'h00
`define BPF_TXA   8'h80

`endif

/* verilog/bpf_pkg.sv */
`include "bpf_consts.svh"

package bpf_pkg;

    typedef struct packed {
        logic [15:0] opcode;
        logic [7:0]  jt;
        logic [7:0]  jf;
        logic [31:0] k;
    } bpf_insn_t;

    typedef enum logic [2:0] {
        CLS_LD   = `BPF_LD,
        CLS_LDX  = `BPF_LDX,
        CLS_ST   = `BPF_ST,
        CLS_STX  = `BPF_STX,
        CLS_ALU  = `BPF_ALU,
        CLS_JMP  = `BPF_JMP,
        CLS_RET  = `BPF_RET,
        CLS_MISC = `BPF_MISC
    } insn_class_e;

    // Same numbering as opcode[7:4] of an ALU instruction
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_MUL = 4'h2,
        ALU_DIV = 4'h3,
        ALU_OR  = 4'h4,
        ALU_AND = 4'h5,
        ALU_LSH = 4'h6,
        ALU_RSH = 4'h7,
        ALU_NEG = 4'h8,
        ALU_MOD = 4'h9,
        ALU_XOR = 4'ha
    } alu_op_e;

    typedef enum logic [2:0] {A_IMM, A_PKT, A_MEM, A_LEN, A_ALU, A_X} a_sel_e;
    typedef enum logic [2:0] {X_IMM, X_PKT, X_MEM, X_LEN, X_MSH, X_A} x_sel_e;
    typedef enum logic [1:0] {PC_PLUS_1, PC_PLUS_JT, PC_PLUS_JF, PC_PLUS_K} pc_sel_e;
    typedef enum logic [1:0] {SZ_W = `BPF_W, SZ_H = `BPF_H, SZ_B = `BPF_B} pkt_size_e;

    typedef struct packed {
        a_sel_e    a_sel;
        logic      a_en;
        x_sel_e    x_sel;
        logic      x_en;
        pc_sel_e   pc_sel;
        logic      pc_en;
        logic      b_sel_k;    // ALU B operand is imm, else X
        alu_op_e   alu_op;
        logic      alu_en;
        logic      mem_src_x;  // Scratch write data from X
        logic      mem_wr_en;
        logic      addr_ind;   // Packet address X + imm
        pkt_size_e pkt_size;
        logic      pc_clear;
    } dp_ctrl_t;

    typedef struct packed {
        logic eq;
        logic gt;
        logic ge;
        logic set;
        logic alu_vld;
        logic oob;
    } dp_flags_t;

endpackage

/* verilog/bpf_alu.sv */
module bpf_alu (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  bpf_pkg::alu_op_e  op,
    input  logic              alu_en,
    input  logic              alu_ack,
    output logic [31:0]       result,
    output logic              alu_vld,
    output logic              eq,
    output logic              gt,
    output logic              ge,
    output logic              set
);
    logic        long_op;
    logic [31:0] quick;
    logic        div_busy;
    logic        div_mod;   // Keep remainder rather than quotient
    logic [4:0]  div_cnt;
    logic [31:0] div_q;
    logic [31:0] div_r;
    logic [31:0] div_d;
    logic [32:0] rem_sh;
    logic [32:0] rem_diff;
    logic [31:0] q_next;
    logic [31:0] r_next;

    // Unsigned compares for the jump tests
    assign eq  = a == b;
    assign gt  = a > b;
    assign ge  = a >= b;
    assign set = (a & b) != '0;

    // Zero divisor stays on the one-cycle path
    assign long_op = (op == bpf_pkg::ALU_DIV || op == bpf_pkg::ALU_MOD) && b != '0;

    always_comb begin
        case (op)
            bpf_pkg::ALU_ADD: quick = a + b;
            bpf_pkg::ALU_SUB: quick = a - b;
            bpf_pkg::ALU_MUL: quick = a * b;
            bpf_pkg::ALU_OR:  quick = a | b;
            bpf_pkg::ALU_AND: quick = a & b;
            bpf_pkg::ALU_LSH: quick = (b[31:5] != '0) ? '0 : a << b[4:0];
            bpf_pkg::ALU_RSH: quick = (b[31:5] != '0) ? '0 : a >> b[4:0];
            bpf_pkg::ALU_NEG: quick = -a;
            bpf_pkg::ALU_XOR: quick = a ^ b;
            default:          quick = '0;   // DIV and MOD by zero
        endcase
    end

    // One restoring step per cycle
    assign rem_sh   = {div_r, div_q[31]};
    assign rem_diff = rem_sh - {1'b0, div_d};
    assign q_next   = {div_q[30:0], ~rem_diff[32]};
    assign r_next   = rem_diff[32] ? rem_sh[31:0] : rem_diff[31:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_vld  <= 1'b0;
            div_busy <= 1'b0;
            div_cnt  <= '0;
        end else begin
            if (alu_ack)
                alu_vld <= 1'b0;
            if (alu_en && long_op) begin
                div_busy <= 1'b1;
                div_cnt  <= '0;
            end else if (alu_en) begin
                alu_vld <= 1'b1;
            end else if (div_busy) begin
                div_cnt <= div_cnt + 5'd1;
                if (div_cnt == 5'd31) begin   // Last of 32 steps
                    div_busy <= 1'b0;
                    alu_vld  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_en) begin
            result  <= quick;
            div_q   <= a;
            div_r   <= '0;
            div_d   <= b;   // Divisor held for the whole run
            div_mod <= op == bpf_pkg::ALU_MOD;
        end else if (div_busy) begin
            div_q <= q_next;
            div_r <= r_next;
            if (div_cnt == 5'd31)
                result <= div_mod ? r_next : q_next;
        end
    end
endmodule

/* verilog/bpf_scratch_mem.sv */
`include "bpf_consts.svh"

module bpf_scratch_mem #(
    parameter int AW = $clog2(`BPF_SCRATCH_DEPTH)
) (
    input  logic          clk,
    input  logic          rst,
    input  logic [AW-1:0] addr,
    input  logic [31:0]   wdata,
    input  logic          wr_en,
    output logic [31:0]   rdata
);
    logic [31:0] mem [`BPF_SCRATCH_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[addr] <= wdata;
    end

    // Read data lands one cycle after the address
    always_ff @(posedge clk) begin
        if (rst)
            rdata <= '0;
        else
            rdata <= mem[addr];
    end
endmodule

/* verilog/bpf_datapath.sv */
`include "bpf_consts.svh"

module bpf_datapath (
    input  logic                    clk,
    input  logic                    rst,
    input  bpf_pkg::dp_ctrl_t       ctrl,
    input  logic                    alu_ack,
    input  logic [31:0]             imm,
    input  logic [7:0]              jt,
    input  logic [7:0]              jf,
    input  logic [`BPF_PLEN_W-1:0]  packet_len,
    input  logic [31:0]             packet_data,
    output logic [`BPF_CODE_AW-1:0] inst_rd_addr,
    output logic [`BPF_BYTE_AW-1:0] packet_rd_addr,
    output bpf_pkg::dp_flags_t      flags,
    output logic [31:0]             a_val
);
    logic [31:0]             a_reg;
    logic [31:0]             x_reg;
    logic [`BPF_CODE_AW-1:0] pc;
    logic [`BPF_CODE_AW-1:0] pc_inc;
    logic [31:0]             b;
    logic [31:0]             alu_result;
    logic                    alu_eq, alu_gt, alu_ge, alu_set, alu_vld;
    logic [31:0]             mem_rdata;
    logic [31:0]             pkt_addr;
    logic [31:0]             pkt_word;
    logic [31:0]             msh_val;
    logic [32:0]             pkt_end;
    logic [2:0]              pkt_bytes;

    assign pkt_addr       = ctrl.addr_ind ? x_reg + imm : imm;
    assign packet_rd_addr = pkt_addr[`BPF_BYTE_AW-1:0];

    // Big-endian word, narrow loads keep the leading bytes
    always_comb begin
        case (ctrl.pkt_size)
            bpf_pkg::SZ_H: begin
                pkt_word  = {16'h0, packet_data[31:16]};
                pkt_bytes = 3'd2;
            end
            bpf_pkg::SZ_B: begin
                pkt_word  = {24'h0, packet_data[31:24]};
                pkt_bytes = 3'd1;
            end
            default: begin
                pkt_word  = packet_data;
                pkt_bytes = 3'd4;
            end
        endcase
    end

    assign msh_val = {26'h0, packet_data[27:24], 2'b00};   // 4 * (byte & 0xf)
    assign pkt_end = {1'b0, pkt_addr} + 33'(pkt_bytes);      // No wrap past 2^32

    always_ff @(posedge clk) begin
        if (rst) begin
            a_reg <= '0;
        end else if (ctrl.a_en) begin
            case (ctrl.a_sel)
                bpf_pkg::A_IMM: a_reg <= imm;
                bpf_pkg::A_PKT: a_reg <= pkt_word;
                bpf_pkg::A_MEM: a_reg <= mem_rdata;
                bpf_pkg::A_LEN: a_reg <= 32'(packet_len);
                bpf_pkg::A_ALU: a_reg <= alu_result;
                default:        a_reg <= x_reg;   // TXA
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x_reg <= '0;
        end else if (ctrl.x_en) begin
            case (ctrl.x_sel)
                bpf_pkg::X_IMM: x_reg <= imm;
                bpf_pkg::X_PKT: x_reg <= pkt_word;
                bpf_pkg::X_MEM: x_reg <= mem_rdata;
                bpf_pkg::X_LEN: x_reg <= 32'(packet_len);
                bpf_pkg::X_MSH: x_reg <= msh_val;
                default:        x_reg <= a_reg;   // TAX
            endcase
        end
    end

    // Jump offsets count from the next instruction
    assign pc_inc = pc + `BPF_CODE_AW'(1);

    always_ff @(posedge clk) begin
        if (rst || ctrl.pc_clear) begin
            pc <= '0;
        end else if (ctrl.pc_en) begin
            case (ctrl.pc_sel)
                bpf_pkg::PC_PLUS_JT: pc <= pc_inc + `BPF_CODE_AW'(jt);
                bpf_pkg::PC_PLUS_JF: pc <= pc_inc + `BPF_CODE_AW'(jf);
                bpf_pkg::PC_PLUS_K:  pc <= pc_inc + imm[`BPF_CODE_AW-1:0];
                default:             pc <= pc_inc;
            endcase
        end
    end

    assign inst_rd_addr = pc;
    assign a_val        = a_reg;
    assign b            = ctrl.b_sel_k ? imm : x_reg;

    bpf_alu u_alu (
        .clk     (clk),
        .rst     (rst),
        .a       (a_reg),
        .b       (b),
        .op      (ctrl.alu_op),
        .alu_en  (ctrl.alu_en),
        .alu_ack (alu_ack),
        .result  (alu_result),
        .alu_vld (alu_vld),
        .eq      (alu_eq),
        .gt      (alu_gt),
        .ge      (alu_ge),
        .set     (alu_set)
    );

    bpf_scratch_mem u_scratch (
        .clk   (clk),
        .rst   (rst),
        .addr  (imm[$clog2(`BPF_SCRATCH_DEPTH)-1:0]),
        .wdata (ctrl.mem_src_x ? x_reg : a_reg),
        .wr_en (ctrl.mem_wr_en),
        .rdata (mem_rdata)
    );

    assign flags = '{eq: alu_eq, gt: alu_gt, ge: alu_ge, set: alu_set,
                     alu_vld: alu_vld, oob: pkt_end > 33'(packet_len)};
endmodule

/* verilog/bpf_controller.sv */
`include "bpf_consts.svh"

module bpf_controller (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  bpf_pkg::bpf_insn_t inst_data,
    input  bpf_pkg::dp_flags_t flags,
    input  logic [31:0]        a_val,
    output bpf_pkg::dp_ctrl_t  ctrl,
    output logic               alu_ack,
    output logic [31:0]        imm,
    output logic [7:0]         jt,
    output logic [7:0]         jf,
    output logic               busy,
    output logic               done,
    output logic [31:0]        ret_val
);
    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_PKT, S_ALU_WAIT, S_DONE
    } state_e;

    state_e               state, state_nxt;
    bpf_pkg::bpf_insn_t   ir;
    bpf_pkg::insn_class_e cls;
    bpf_pkg::a_sel_e      a_sel_dec;
    bpf_pkg::x_sel_e      x_sel_dec;
    logic [7:0]           code;
    logic [7:0]           mode;
    logic                 is_load, is_pkt, is_mem;
    logic                 mem_wait;   // Scratch read still in flight
    logic                 take;
    logic                 ret_ld;
    logic [31:0]          ret_nxt;

    assign code    = ir.opcode[7:0];
    assign cls     = bpf_pkg::insn_class_e'(code[2:0]);
    assign mode    = code & `BPF_MODE_MASK;
    assign is_load = cls == bpf_pkg::CLS_LD || cls == bpf_pkg::CLS_LDX;
    assign is_pkt  = is_load && (mode == `BPF_ABS || mode == `BPF_IND || mode == `BPF_MSH);
    assign is_mem  = is_load && mode == `BPF_MEM;

    always_comb begin
        case (mode)
            `BPF_IMM: begin a_sel_dec = bpf_pkg::A_IMM; x_sel_dec = bpf_pkg::X_IMM; end
            `BPF_MEM: begin a_sel_dec = bpf_pkg::A_MEM; x_sel_dec = bpf_pkg::X_MEM; end
            `BPF_LEN: begin a_sel_dec = bpf_pkg::A_LEN; x_sel_dec = bpf_pkg::X_LEN; end
            `BPF_MSH: begin a_sel_dec = bpf_pkg::A_PKT; x_sel_dec = bpf_pkg::X_MSH; end
            default:  begin a_sel_dec = bpf_pkg::A_PKT; x_sel_dec = bpf_pkg::X_PKT; end
        endcase
        if (cls == bpf_pkg::CLS_MISC) begin   // TXA and TAX
            a_sel_dec = bpf_pkg::A_X;
            x_sel_dec = bpf_pkg::X_A;
        end
    end

    always_comb begin
        case (code & `BPF_OP_MASK)
            `BPF_JEQ:  take = flags.eq;
            `BPF_JGT:  take = flags.gt;
            `BPF_JGE:  take = flags.ge;
            `BPF_JSET: take = flags.set;
            default:   take = 1'b1;
        endcase
    end

    always_comb begin
        ctrl           = '0;
        ctrl.a_sel     = a_sel_dec;
        ctrl.x_sel     = x_sel_dec;
        ctrl.b_sel_k   = (code & `BPF_SRC_MASK) == `BPF_K;
        ctrl.alu_op    = bpf_pkg::alu_op_e'(code[7:4]);
        ctrl.mem_src_x = cls == bpf_pkg::CLS_STX;
        ctrl.addr_ind  = mode == `BPF_IND;
        ctrl.pkt_size  = (mode == `BPF_MSH) ? bpf_pkg::SZ_B : bpf_pkg::pkt_size_e'(code[4:3]);
        alu_ack        = 1'b0;
        ret_ld         = 1'b0;
        ret_nxt        = '0;
        state_nxt      = state;
        case (state)
            S_IDLE: begin
                if (start) begin
                    ctrl.pc_clear = 1'b1;
                    state_nxt     = S_FETCH;
                end
            end
            S_FETCH:  state_nxt = S_DECODE;
            S_DECODE: state_nxt = S_EXEC;
            S_EXEC: begin
                state_nxt = S_FETCH;
                case (cls)
                    bpf_pkg::CLS_LD, bpf_pkg::CLS_LDX: begin
                        if (is_pkt && flags.oob) begin
                            ret_ld    = 1'b1;   // Out of bounds returns 0
                            state_nxt = S_DONE;
                        end else if (is_pkt) begin
                            state_nxt = S_PKT;
                        end else if (is_mem && !mem_wait) begin
                            state_nxt = S_EXEC;
                        end else begin
                            ctrl.a_en  = cls == bpf_pkg::CLS_LD;
                            ctrl.x_en  = cls == bpf_pkg::CLS_LDX;
                            ctrl.pc_en = 1'b1;
                        end
                    end
                    bpf_pkg::CLS_ST, bpf_pkg::CLS_STX: begin
                        ctrl.mem_wr_en = 1'b1;
                        ctrl.pc_en     = 1'b1;
                    end
                    bpf_pkg::CLS_ALU: begin
                        ctrl.alu_en = 1'b1;
                        state_nxt   = S_ALU_WAIT;
                    end
                    bpf_pkg::CLS_JMP: begin
                        ctrl.pc_en = 1'b1;
                        if ((code & `BPF_OP_MASK) == `BPF_JA)
                            ctrl.pc_sel = bpf_pkg::PC_PLUS_K;
                        else
                            ctrl.pc_sel = take ? bpf_pkg::PC_PLUS_JT : bpf_pkg::PC_PLUS_JF;
                    end
                    bpf_pkg::CLS_RET: begin
                        ret_ld    = 1'b1;
                        ret_nxt   = ((code & `BPF_RVAL_MASK) == `BPF_RET_A) ? a_val : ir.k;
                        state_nxt = S_DONE;
                    end
                    default: begin
                        ctrl.a_en  = (code & `BPF_MISCOP_MASK) == `BPF_TXA;
                        ctrl.x_en  = (code & `BPF_MISCOP_MASK) == `BPF_TAX;
                        ctrl.pc_en = 1'b1;
                    end
                endcase
            end
            S_PKT: begin   // Packet word is back
                ctrl.a_en  = cls == bpf_pkg::CLS_LD;
                ctrl.x_en  = cls == bpf_pkg::CLS_LDX;
                ctrl.pc_en = 1'b1;
                state_nxt  = S_FETCH;
            end
            S_ALU_WAIT: begin
                if (flags.alu_vld) begin
                    ctrl.a_sel = bpf_pkg::A_ALU;
                    ctrl.a_en  = 1'b1;
                    ctrl.pc_en = 1'b1;
                    alu_ack    = 1'b1;
                    state_nxt  = S_FETCH;
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            mem_wait <= 1'b0;
        end else begin
            state    <= state_nxt;
            mem_wait <= state == S_EXEC && is_mem && !mem_wait;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DECODE)
            ir <= inst_data;
        if (ret_ld)
            ret_val <= ret_nxt;
    end

    assign imm  = ir.k;
    assign jt   = ir.jt;
    assign jf   = ir.jf;
    assign busy = state != S_IDLE;
    assign done = state == S_DONE;
endmodule

/* verilog/bpf_cpu.sv */
`include "bpf_consts.svh"

module bpf_cpu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [`BPF_PLEN_W-1:0]  packet_len,
    output logic [`BPF_CODE_AW-1:0] inst_rd_addr,
    input  bpf_pkg::bpf_insn_t      inst_data,
    output logic [`BPF_BYTE_AW-1:0] packet_rd_addr,
    input  logic [31:0]             packet_data,
    output logic                    busy,
    output logic                    done,
    output logic [31:0]             ret_val
);
    bpf_pkg::dp_ctrl_t  ctrl;
    bpf_pkg::dp_flags_t flags;
    logic [31:0]        a_val;
    logic [31:0]        imm;
    logic [7:0]         jt;
    logic [7:0]         jf;
    logic               alu_ack;

    bpf_controller u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .inst_data (inst_data),
        .flags     (flags),
        .a_val     (a_val),
        .ctrl      (ctrl),
        .alu_ack   (alu_ack),
        .imm       (imm),
        .jt        (jt),
        .jf        (jf),
        .busy      (busy),
        .done      (done),
        .ret_val   (ret_val)
    );

    bpf_datapath u_dp (
        .clk            (clk),
        .rst            (rst),
        .ctrl           (ctrl),
        .alu_ack        (alu_ack),
        .imm            (imm),
        .jt             (jt),
        .jf             (jf),
        .packet_len     (packet_len),
        .packet_data    (packet_data),
        .inst_rd_addr   (inst_rd_addr),
        .packet_rd_addr (packet_rd_addr),
        .flags          (flags),
        .a_val          (a_val)
    );
endmodule

/* tests/tb_bpf_cpu.sv */
`include "bpf_consts.svh"

module tb_bpf_cpu;
    logic                    clk;
    logic                    rst;
    logic                    start;
    logic [`BPF_PLEN_W-1:0]  packet_len;
    logic [`BPF_CODE_AW-1:0] inst_rd_addr;
    bpf_pkg::bpf_insn_t      inst_data;
    logic [`BPF_BYTE_AW-1:0] packet_rd_addr;
    logic [31:0]             packet_data;
    logic                    busy;
    logic                    done;
    logic [31:0]             ret_val;

    bpf_pkg::bpf_insn_t imem [1 << `BPF_CODE_AW];
    logic [7:0]         pkt [1 << `BPF_BYTE_AW];
    int                 prog_len;
    int                 errors;
    int                 seed = 32'h4c26_ade1;
    int                 run_cycles;   // Length of the last run in cycles
    logic [31:0]        expected;

    bpf_cpu u_dut (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .packet_len     (packet_len),
        .inst_rd_addr   (inst_rd_addr),
        .inst_data      (inst_data),
        .packet_rd_addr (packet_rd_addr),
        .packet_data    (packet_data),
        .busy           (busy),
        .done           (done),
        .ret_val        (ret_val)
    );

    always #2 clk = ~clk;

    // Memory models with a one-cycle registered read
    always @(posedge clk) begin
        inst_data   <= imem[inst_rd_addr];
        packet_data <= {pkt[packet_rd_addr], pkt[12'(packet_rd_addr + 1)],
                        pkt[12'(packet_rd_addr + 2)], pkt[12'(packet_rd_addr + 3)]};
    end

    task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            errors++;
            $display("[FAIL] %0t %s: expected %h, got %h", $time, what, exp, got);
        end
    endtask

    // Compares every result as done is seen
    always @(negedge clk) begin
        if (!rst && done)
            check_equal("ret_val", expected, ret_val);
    end

    function automatic logic [31:0] packet_word(input logic [31:0] addr);
        return {pkt[addr[11:0]], pkt[12'(addr + 1)], pkt[12'(addr + 2)], pkt[12'(addr + 3)]};
    endfunction

    // Interpreter for classic BPF over imem and pkt
    function automatic logic [31:0] interpret_program(input logic [15:0] len);
        logic [31:0]        a, x, k, b, v, addr;
        logic [31:0]        mem [16];
        logic [9:0]         pc;
        logic [7:0]         code, mode;
        logic               cond;
        int                 sz;
        bpf_pkg::bpf_insn_t in;
        a = 0;
        x = 0;
        pc = 0;
        for (int i = 0; i < 16; i++)
            mem[i] = 0;
        for (int step = 0; step < 1000; step++) begin
            in   = imem[pc];
            code = in.opcode[7:0];
            mode = code & 8'he0;
            k    = in.k;
            pc   = pc + 10'd1;
            case (code[2:0])
                3'h0, 3'h1: begin
                    sz   = (code[4:3] == 2'h0) ? 4 : (code[4:3] == 2'h1) ? 2 : 1;
                    addr = (mode == 8'h40) ? x + k : k;
                    if (mode == 8'h20 || mode == 8'h40 || mode == 8'ha0) begin
                        if (mode == 8'ha0)
                            sz = 1;
                        if ({1'b0, addr} + 33'(sz) > 33'(len))
                            return 0;   // Past the end of the packet
                        v = packet_word(addr) >> ((4 - sz) * 8);
                        if (mode == 8'ha0)
                            v = (v & 32'hf) * 4;   // IP header length in bytes
                    end else if (mode == 8'h60) v = mem[k[3:0]];
                    else if (mode == 8'h80) v = 32'(len);
                    else v = k;
                    if (code[0]) x = v;
                    else a = v;
                end
                3'h2: mem[k[3:0]] = a;
                3'h3: mem[k[3:0]] = x;
                3'h4: begin
                    b = code[3] ? x : k;
                    case (code[7:4])
                        4'h0: a = a + b;
                        4'h1: a = a - b;
                        4'h2: a = a * b;
                        4'h3: a = (b == 0) ? 0 : a / b;
                        4'h4: a = a | b;
                        4'h5: a = a & b;
                        4'h6: a = (b >= 32) ? 0 : a << b;
                        4'h7: a = (b >= 32) ? 0 : a >> b;
                        4'h8: a = -a;
                        4'h9: a = (b == 0) ? 0 : a % b;
                        4'ha: a = a ^ b;
                        default: a = 0;
                    endcase
                end
                3'h5: begin
                    b = code[3] ? x : k;
                    case (code[7:4])
                        4'h1: cond = a == b;
                        4'h2: cond = a > b;
                        4'h3: cond = a >= b;
                        default: cond = (a & b) != 0;
                    endcase
                    if (code[7:4] == 4'h0) pc = pc + k[9:0];
                    else pc = pc + (cond ? 10'(in.jt) : 10'(in.jf));
                end
                3'h6: return ((code & 8'h18) == 8'h10) ? a : k;
                default: begin
                    if (code[7]) a = x;   // TXA
                    else x = a;
                end
            endcase
        end
        return 0;
    endfunction

    task automatic emit(input logic [15:0] op, input logic [7:0] jt, input logic [7:0] jf,
                        input logic [31:0] k);
        imem[prog_len] = '{opcode: op, jt: jt, jf: jf, k: k};
        prog_len++;
    endtask

    // One run from start to done; poke raises start again while busy
    task automatic run_program(input logic [15:0] len, input bit poke);
        int cycles;
        expected   = interpret_program(len);
        packet_len = len;
        start      = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        check_equal("busy during run", 1, 32'(busy));
        while (!done) begin
            @(negedge clk);
            cycles++;
            start = poke && cycles == 3;
            check_equal("busy during run", 1, 32'(busy));
            if (cycles >= 5000) begin
                $display("Timeout: done never came after start");
                $display("Test FAILED");
                $finish;
            end
        end
        start      = 1'b0;
        run_cycles = cycles;
        @(negedge clk);
        check_equal("done after one cycle", 0, 32'(done));
        check_equal("busy after done", 0, 32'(busy));
    endtask

    task automatic alu_case(input logic [3:0] op, input bit src_x, input logic [31:0] a,
                            input logic [31:0] b);
        prog_len = 0;
        emit(16'h0000, 0, 0, a);
        emit(16'h0001, 0, 0, src_x ? b : ~b);   // Unused operand differs
        emit({8'h0, op, src_x, 3'b100}, 0, 0, src_x ? ~b : b);
        emit(16'h0016, 0, 0, 0);
        run_program(64, 0);
    endtask

    task automatic jump_case(input logic [3:0] test, input bit src_x, input logic [31:0] a,
                             input logic [31:0] b);
        prog_len = 0;
        emit(16'h0000, 0, 0, a);
        emit(16'h0001, 0, 0, src_x ? b : ~b);
        emit({8'h0, test, src_x, 3'b101}, 1, 0, (test == 0) ? 32'd1 : (src_x ? ~b : b));
        emit(16'h0006, 0, 0, 32'h111);   // Not taken
        emit(16'h0006, 0, 0, 32'h222);   // Taken
        run_program(64, 0);
    endtask

    task automatic fill_packet(input int n);
        for (int i = 0; i < n; i++)
            pkt[i] = 8'($random(seed));
    endtask

    initial begin
        logic [31:0] a, b, r1, r2;
        int          len, off, plain_cycles;
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        packet_len = '0;
        inst_data = '0;
        packet_data = '0;
        errors = 0;
        expected = '0;
        run_cycles = 0;
        for (int i = 0; i < (1 << `BPF_BYTE_AW); i++)
            pkt[i] = 8'(i ^ (i >> 8) ^ 8'h5a);   // Depends on every address bit
        for (int i = 0; i < (1 << `BPF_CODE_AW); i++)
            imem[i] = '{opcode: 16'h0006, jt: 0, jf: 0, k: 32'(i)};
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_equal("busy after reset", 0, 32'(busy));
        check_equal("done after reset", 0, 32'(done));
        check_equal("inst_rd_addr after reset", 0, 32'(inst_rd_addr));
        prog_len = 0;
        emit(16'h0000, 0, 0, 32'hcafe_f00d);
        emit(16'h0016, 0, 0, 0);
        run_program(64, 0);

        // Every ALU op with K and with X operand
        for (int op = 0; op <= 10; op++) begin
            for (int s = 0; s < 2; s++)
                alu_case(4'(op), 1'(s), $random(seed), $random(seed) & 32'h0fff_ffff);
        end
        alu_case(4'h3, 0, $random(seed), 0);
        alu_case(4'h9, 1, $random(seed), 0);
        alu_case(4'h6, 0, $random(seed), 32 + ($random(seed) & 32'h3f));
        alu_case(4'h7, 1, $random(seed), 32'h8000_0020);
        alu_case(4'h7, 0, $random(seed), 31);

        for (int i = 0; i < 40; i++) begin
            a = $random(seed) & 32'hff;
            b = (i % 3 == 0) ? a : $random(seed) & 32'hff;
            jump_case(4'(1 + i % 4), 1'((i / 4) % 2), a, b);
        end
        jump_case(4'h0, 0, $random(seed), $random(seed));

        // Scratch memory and register moves
        fill_packet(128);
        r1 = $random(seed);
        r2 = $random(seed);
        prog_len = 0;
        emit(16'h0000, 0, 0, r1);
        emit(16'h0002, 0, 0, 3);
        emit(16'h0001, 0, 0, r2);
        emit(16'h0003, 0, 0, 7);
        emit(16'h0000, 0, 0, 0);
        emit(16'h0060, 0, 0, 7);
        emit(16'h0007, 0, 0, 0);   // TAX
        emit(16'h0060, 0, 0, 3);
        emit(16'h000c, 0, 0, 0);   // A += X
        emit(16'h0002, 0, 0, 5);
        emit(16'h00b1, 0, 0, 2);   // LDX MSH
        emit(16'h0087, 0, 0, 0);   // TXA
        emit(16'h0061, 0, 0, 5);
        emit(16'h000c, 0, 0, 0);
        emit(16'h0016, 0, 0, 0);
        run_program(64, 0);

        // Packet loads with some past the end
        for (int i = 0; i < 36; i++) begin
            prog_len = 0;
            emit(16'h0001, 0, 0, $random(seed) & 32'h1f);
            emit({8'h0, (i % 2) ? 3'b010 : 3'b001, 2'(i % 3), 3'b000}, 0, 0,
                 $random(seed) & 32'h3f);
            emit(16'h0016, 0, 0, 0);
            run_program(16'(48 + i % 20), 0);
        end
        prog_len = 0;
        emit(16'h0080, 0, 0, 0);
        emit(16'h0016, 0, 0, 0);
        run_program(16'h0123, 0);
        prog_len = 0;
        emit(16'h0020, 0, 0, 62);
        emit(16'h0016, 0, 0, 0);
        run_program(64, 0);

        // IPv4 TCP port filter
        prog_len = 0;
        emit(16'h0028, 0, 0, 12);
        emit(16'h0015, 0, 6, 32'h0800);
        emit(16'h0030, 0, 0, 23);
        emit(16'h0015, 0, 4, 6);
        emit(16'h00b1, 0, 0, 14);
        emit(16'h0048, 0, 0, 16);
        emit(16'h0015, 0, 1, 80);
        emit(16'h0006, 0, 0, 32'hffff);
        emit(16'h0006, 0, 0, 0);
        for (int i = 0; i < 50; i++) begin
            fill_packet(128);
            len = 20 + ($random(seed) & 32'h3f);
            if (i % 4 != 0) begin
                pkt[12] = 8'h08;
                pkt[13] = 8'h00;
            end
            if (i % 3 != 0)
                pkt[23] = 8'h06;
            off = 14 + 4 * int'(pkt[14] & 8'h0f) + 2;
            if (i % 2 == 0) begin
                pkt[off]     = 8'h00;
                pkt[off + 1] = 8'd80;
            end
            run_program(16'(len), 0);
            plain_cycles = run_cycles;
            run_program(16'(len), 1);   // Same packet with start raised mid run
            check_equal("run length with start while busy", plain_cycles, run_cycles);
        end

        $display("Checks finished with %0d errors", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end
endmodule

/* vlog.f */
+incdir+include
verilog/bpf_pkg.sv
verilog/bpf_alu.sv
verilog/bpf_scratch_mem.sv
verilog/bpf_datapath.sv
verilog/bpf_controller.sv
verilog/bpf_cpu.sv
tests/tb_bpf_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bpf_cpu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS = $(filter-out +incdir%,$(shell cat vlog.f)) include/bpf_consts.svh
SIM  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): vlog.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f vlog.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
